// ==== dv/uart_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_checker #(
    parameter int OVERSAMPLE = 16,                             // clocks per bit
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    uart_clk,
    input  logic                    sys_rst_n,
    input  uart_bus_pkg::apb_req_t  apb_req,
    input  uart_bus_pkg::apb_rsp_t  apb_rsp,
    input  logic                    txd,
    output int                      error_count,
    output int                      pending,                   // accepted bytes not yet seen on txd
    output logic                    line_idle                  // no frame in flight
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    // receiver hands over the byte mid stop bit, 2 sync + 1 edge detect later
    localparam int rx_done  = 9 * OVERSAMPLE + OVERSAMPLE / 2 + 3;
    localparam int slot_len = slot_bits * OVERSAMPLE;          // clocks per transmit slot

    logic [7:0] tx_q [$];                                      // bytes in order of acceptance
    int         fifo_cnt;                                      // model FIFO occupancy
    int         tx_slot;                                       // cycle of the transmit slot, 0 idle
    logic       exp_busy;
    logic       framing;
    int         cnt;                                           // clocks since start bit seen
    int         bit_k;
    logic [7:0] shifted;
    logic [7:0] frame_byte;
    logic [7:0] exp_byte;
    logic       exp_valid;
    logic       exp_overrun;
    logic       after_reset;
    logic [7:0] exp_rdata;
    logic       exp_err;

    task automatic show_mismatch(input string msg);
        error_count++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic raise_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    always @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tx_q.delete();
            fifo_cnt    = 0;
            tx_slot     = 0;
            framing     = 1'b0;
            cnt         = 0;
            exp_valid   = 1'b0;
            exp_overrun = 1'b0;
            exp_byte    = '0;
            after_reset = 1'b1;
            pending     = 0;
            line_idle   = 1'b1;
        end else begin
            if (after_reset && !txd)
                raise_error("txd is not high after reset");
            after_reset = 1'b0;
            // transmit slot, fetch is cycle 1 and the start bit cycle 2
            exp_busy = (tx_slot != 0) && (tx_slot < slot_len);
            if (tx_slot == 0 || tx_slot == slot_len)
                tx_slot = (fifo_cnt > 0) ? 1 : 0;              // idle cycle, fetch if a byte waits
            else
                tx_slot = tx_slot + 1;
            // txd frame decoder, samples taken mid-bit
            if (!framing) begin
                if (!txd) begin
                    framing  = 1'b1;
                    cnt      = 1;
                    fifo_cnt = fifo_cnt - 1;                   // pop lands with the falling edge
                    if (fifo_cnt < 0)
                        raise_error("start bit sent while the FIFO model is empty");
                    if (tx_slot != 3)
                        show_mismatch("start bit outside the slot timing");
                end
            end else begin
                cnt = cnt + 1;
                bit_k = cnt / OVERSAMPLE;
                if (cnt % OVERSAMPLE == OVERSAMPLE / 2 && bit_k <= 9) begin
                    if (bit_k == 0 && txd)
                        show_mismatch("start bit is high at mid-bit");
                    else if (bit_k >= 1 && bit_k <= 8)
                        shifted[bit_k-1] = txd;                // lsb first
                    else if (bit_k == 9) begin
                        if (!txd)
                            show_mismatch("stop level is low");
                        frame_byte = shifted;
                        if (tx_q.size() == 0)
                            raise_error("frame on txd with no byte written");
                        else begin
                            frame_byte = tx_q.pop_front();     // loopback expects the written byte
                            if (frame_byte != shifted)
                                show_mismatch($sformatf("txd byte %02h, expected %02h",
                                                        shifted, frame_byte));
                        end
                    end
                end
            end
            // apb access phase
            if (apb_req.psel && apb_req.penable) begin
                exp_rdata = '0;
                exp_err   = 1'b0;
                case (apb_req.paddr)
                    reg_txdata: exp_err = apb_req.pwrite && (fifo_cnt >= FIFO_DEPTH);
                    reg_rxdata: begin
                        exp_err = apb_req.pwrite;
                        if (!apb_req.pwrite && exp_valid)
                            exp_rdata = exp_byte;
                    end
                    reg_status: begin
                        if (!apb_req.pwrite)
                            exp_rdata = {2'b00, fifo_cnt >= FIFO_DEPTH, fifo_cnt == 0, exp_busy,
                                         exp_valid, exp_overrun, 1'b0};
                    end
                    default: exp_err = 1'b1;
                endcase
                if (apb_rsp.pready !== 1'b1)
                    show_mismatch("pready low in the access phase");
                if (apb_rsp.pslverr !== exp_err)
                    show_mismatch($sformatf("pslverr %b at addr %h, expected %b",
                                            apb_rsp.pslverr, apb_req.paddr, exp_err));
                if (!apb_req.pwrite && apb_rsp.prdata !== exp_rdata)
                    show_mismatch($sformatf("prdata %02h at addr %h, expected %02h",
                                            apb_rsp.prdata, apb_req.paddr, exp_rdata));
                if (apb_req.pwrite && apb_req.paddr == reg_txdata && !exp_err) begin
                    tx_q.push_back(apb_req.pwdata);
                    fifo_cnt = fifo_cnt + 1;
                end
                if (apb_req.pwrite && apb_req.paddr == reg_status && apb_req.pwdata[1])
                    exp_overrun = 1'b0;
                if (!apb_req.pwrite && apb_req.paddr == reg_rxdata)
                    exp_valid = 1'b0;
            end
            // loopback byte reaches the holding register
            if (framing && cnt == rx_done) begin
                if (exp_valid)
                    exp_overrun = 1'b1;                        // still unread, a read here cleared it
                exp_valid = 1'b1;
                exp_byte  = frame_byte;
                framing   = 1'b0;
            end
            pending   = tx_q.size();
            line_idle = !framing;
        end
    end

    initial error_count = 0;

endmodule

`default_nettype wire

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb;
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int clk_period = 20;
    localparam int oversample = 4;                             // short bits keep the run fast
    localparam int fifo_depth = 8;
    localparam int max_bytes  = 64;                            // upper bound on frames sent
    localparam int timeout_ns = (max_bytes * slot_bits * oversample + 2000) * clk_period;

    logic     uart_clk;
    logic     sys_rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     txd;
    int       error_count;
    int       pending;
    logic     line_idle;
    int       n_burst;

    uart_top #(.OVERSAMPLE(oversample), .FIFO_DEPTH(fifo_depth)) i_dut (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .txd       (txd),
        .rxd       (txd)                                       // loopback
    );

    uart_checker #(.OVERSAMPLE(oversample), .FIFO_DEPTH(fifo_depth)) i_checker (
        .uart_clk    (uart_clk),
        .sys_rst_n   (sys_rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .txd         (txd),
        .error_count (error_count),
        .pending     (pending),
        .line_idle   (line_idle)
    );

    initial begin
        uart_clk = 1'b0;
        forever #(clk_period / 2) uart_clk = ~uart_clk;
    end

    // setup phase, access phase, then bus released
    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [7:0] data);
        @(negedge uart_clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge uart_clk);
        apb_req.penable = 1'b1;
        @(negedge uart_clk);
        apb_req = '0;
    endtask

    task automatic wait_drain();
        while (pending != 0 || !line_idle)
            @(negedge uart_clk);
        repeat (2) @(negedge uart_clk);
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: the transmit queue did not drain in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha72c_ddd2));
        apb_req   = '0;
        sys_rst_n = 1'b0;
        repeat (2) @(posedge uart_clk);
        @(negedge uart_clk);
        sys_rst_n = 1'b1;
        apb_access(1'b0, reg_status, 8'h00);                   // only fifo_empty after reset
        // illegal accesses
        apb_access(1'b1, reg_rxdata, 8'($urandom));
        apb_access(1'b0, 4'hc, 8'h00);
        apb_access(1'b1, 4'h2, 8'($urandom));
        apb_access(1'b0, reg_status, 8'h00);
        // single byte loopback
        apb_access(1'b1, reg_txdata, 8'($urandom));
        wait_drain();
        apb_access(1'b0, reg_rxdata, 8'h00);
        apb_access(1'b0, reg_status, 8'h00);
        apb_access(1'b0, reg_rxdata, 8'h00);                   // empty holding reg reads 0
        // two frames without a read give an overrun
        apb_access(1'b1, reg_txdata, 8'($urandom));
        apb_access(1'b1, reg_txdata, 8'($urandom));
        wait_drain();
        apb_access(1'b0, reg_status, 8'h00);
        apb_access(1'b0, reg_rxdata, 8'h00);
        apb_access(1'b1, reg_status, 8'h03);
        apb_access(1'b0, reg_status, 8'h00);
        // bursts faster than the line, overfilling the FIFO
        for (int r = 0; r < 4; r++) begin
            n_burst = 10 + int'($urandom % 5);
            for (int i = 0; i < n_burst; i++) begin
                apb_access(1'b1, reg_txdata, 8'($urandom));
                if ($urandom % 4 == 0)
                    apb_access(1'b0, reg_status, 8'h00);
            end
            wait_drain();
            apb_access(1'b0, reg_status, 8'h00);
            apb_access(1'b0, reg_rxdata, 8'h00);
            apb_access(1'b1, reg_status, 8'h03);
            apb_access(1'b0, reg_status, 8'h00);
        end
        repeat (4) @(negedge uart_clk);
        $display("run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/uart_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_apb_regs (
    input  logic                                uart_clk,
    input  logic                                sys_rst_n,
    input  uart_bus_pkg::apb_req_t              apb_req,
    output uart_bus_pkg::apb_rsp_t              apb_rsp,
    output logic                                push,          // tx FIFO write strobe
    output logic [uart_cfg_pkg::data_bits-1:0]  wr_data,
    input  logic                                fifo_full,
    input  logic                                fifo_empty,
    input  logic                                tx_busy,
    input  logic [uart_cfg_pkg::data_bits-1:0]  rx_byte,
    input  logic                                rx_valid_pulse,
    input  logic                                rx_frame_err_pulse
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int pad_w = $bits(apb_rsp.prdata) - $bits(uart_status_t);

    logic                 access;                              // apb access phase
    logic                 wr_en;
    logic                 rd_en;
    uart_reg_e            reg_addr;
    uart_status_t         status;
    uart_status_t         clear_mask;                          // write data seen as status bits
    logic                 rx_read;
    logic                 status_clear;
    logic [data_bits-1:0] rx_data;                             // holding register
    logic                 rx_valid;
    logic                 rx_overrun;
    logic                 rx_frame_err;

    assign access       = apb_req.psel && apb_req.penable;
    assign wr_en        = access && apb_req.pwrite;
    assign rd_en        = access && !apb_req.pwrite;
    assign reg_addr     = uart_reg_e'(apb_req.paddr);
    assign clear_mask   = uart_status_t'(apb_req.pwdata[$bits(uart_status_t)-1:0]);
    assign rx_read      = rd_en && (reg_addr == reg_rxdata);
    assign status_clear = wr_en && (reg_addr == reg_status);
    assign push         = wr_en && (reg_addr == reg_txdata) && !fifo_full; // full drops the byte
    assign wr_data      = apb_req.pwdata;
    assign status       = '{fifo_full, fifo_empty, tx_busy, rx_valid, rx_overrun, rx_frame_err};

    // zero wait state response
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = '0;
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            case (reg_addr)
                reg_txdata: apb_rsp.pslverr = apb_req.pwrite && fifo_full;
                reg_rxdata: begin
                    apb_rsp.pslverr = apb_req.pwrite;          // read only
                    if (!apb_req.pwrite && rx_valid)
                        apb_rsp.prdata = rx_data;              // zero when nothing held
                end
                reg_status: begin
                    if (!apb_req.pwrite)
                        apb_rsp.prdata = {{pad_w{1'b0}}, status};
                end
                default: apb_rsp.pslverr = 1'b1;               // unmapped address
            endcase
        end
    end

    // rx flags
    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rx_valid     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            if (rx_valid_pulse)
                rx_valid <= 1'b1;                              // new byte wins over a read
            else if (rx_read)
                rx_valid <= 1'b0;
            if (rx_valid_pulse && rx_valid && !rx_read)
                rx_overrun <= 1'b1;                            // unread byte overwritten
            else if (status_clear && clear_mask.rx_overrun)
                rx_overrun <= 1'b0;
            if (rx_frame_err_pulse)
                rx_frame_err <= 1'b1;
            else if (status_clear && clear_mask.rx_frame_err)
                rx_frame_err <= 1'b0;
        end
    end

    always_ff @(posedge uart_clk) begin
        if (rx_valid_pulse)
            rx_data <= rx_byte;
    end

    a_penable_psel: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

// ==== logic/uart_bus_pkg.sv ====
`default_nettype none

package uart_bus_pkg;

    // apb request, master to slave
    typedef struct packed {
        logic       psel;
        logic       penable;                   // access phase
        logic       pwrite;
        logic [3:0] paddr;                     // byte address of the register
        logic [7:0] pwdata;
    } apb_req_t;

    // apb response, slave to master
    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;                    // tied high, no wait states
        logic       pslverr;
    } apb_rsp_t;

    // register map
    typedef enum logic [3:0] {
        reg_txdata = 4'h0,                     // write only, pushes into the tx FIFO
        reg_rxdata = 4'h4,                     // read only, read clears rx_valid
        reg_status = 4'h8                      // read status, write 1s to clear the error bits
    } uart_reg_e;

endpackage

`default_nettype wire

// ==== logic/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

    localparam int data_bits = 8;              // bits per character
    localparam int slot_bits = 12;             // bit periods per transmit slot, start + 8 data + 3 stop

    // transmitter FSM
    typedef enum logic [1:0] {
        tx_idle  = 2'd0,                       // waiting for a byte in the FIFO
        tx_fetch = 2'd1,                       // read request cycle, byte captured at its end
        tx_shift = 2'd2                        // start, data and stop level on the line
    } tx_state_e;

    // receiver FSM
    typedef enum logic [1:0] {
        rx_idle  = 2'd0,                       // line high, looking for a falling edge
        rx_start = 2'd1,                       // checking the start bit at half a bit
        rx_data  = 2'd2,                       // sampling the data bits mid-bit
        rx_stop  = 2'd3                        // sampling the stop bit
    } rx_state_e;

    // status register layout, msb first
    typedef struct packed {
        logic fifo_full;                       // bit 5
        logic fifo_empty;                      // bit 4
        logic tx_busy;                         // bit 3
        logic rx_valid;                        // bit 2, unread byte in the holding register
        logic rx_overrun;                      // bit 1, sticky
        logic rx_frame_err;                    // bit 0, sticky
    } uart_status_t;

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
    parameter int OVERSAMPLE = 16                              // clocks per bit
) (
    input  logic                                uart_clk,
    input  logic                                sys_rst_n,
    input  logic                                rxd,           // asynchronous serial input
    output logic [uart_cfg_pkg::data_bits-1:0]  rx_byte,
    output logic                                rx_valid_pulse,
    output logic                                rx_frame_err_pulse
);
    import uart_cfg_pkg::*;

    localparam int cnt_w = $clog2(OVERSAMPLE);
    localparam int bit_w = $clog2(data_bits);

    logic                 rxd_meta;                            // first synchronizer stage
    logic                 rxd_sync;
    rx_state_e            state;
    logic [cnt_w-1:0]     cnt;                                 // clocks into the current bit
    logic [bit_w-1:0]     bit_cnt;                             // data bits taken so far
    logic [data_bits-1:0] shift_reg;
    logic                 half_done;
    logic                 bit_done;

    assign half_done = (cnt == cnt_w'(OVERSAMPLE / 2 - 1));
    assign bit_done  = (cnt == cnt_w'(OVERSAMPLE - 1));

    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rxd_meta <= 1'b1;                                  // line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= rx_idle;
            cnt     <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rxd_sync)
                        state <= rx_start;                     // possible start edge
                end
                rx_start: begin
                    if (half_done) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync ? rx_idle : rx_data; // high here is a glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_w'(data_bits - 1))
                            state <= rx_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_done)
                        state <= rx_idle;                      // byte handed over this cycle
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge uart_clk) begin
        if (state == rx_data && bit_done)
            shift_reg <= {rxd_sync, shift_reg[data_bits-1:1]}; // lsb arrives first
    end

    assign rx_byte            = shift_reg;
    assign rx_valid_pulse     = (state == rx_stop) && bit_done; // middle of the stop bit
    assign rx_frame_err_pulse = rx_valid_pulse && !rxd_sync;    // stop bit sampled low

    a_pulse_single: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        (rx_valid_pulse || rx_frame_err_pulse) |=> !(rx_valid_pulse || rx_frame_err_pulse));

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_top #(
    parameter int OVERSAMPLE = 16,                             // uart_clk cycles per bit
    parameter int FIFO_DEPTH = 8                               // tx FIFO entries
) (
    input  logic                    uart_clk,
    input  logic                    sys_rst_n,
    input  uart_bus_pkg::apb_req_t  apb_req,
    output uart_bus_pkg::apb_rsp_t  apb_rsp,
    output logic                    txd,
    input  logic                    rxd
);
    import uart_cfg_pkg::*;

    logic                 push;
    logic [data_bits-1:0] wr_data;
    logic                 rd_req;                              // FIFO pop
    logic [data_bits-1:0] rd_data;
    logic                 fifo_full;
    logic                 fifo_empty;
    logic                 tx_busy;
    logic [data_bits-1:0] rx_byte;
    logic                 rx_valid_pulse;
    logic                 rx_frame_err_pulse;

    uart_apb_regs i_regs (
        .uart_clk           (uart_clk),
        .sys_rst_n          (sys_rst_n),
        .apb_req            (apb_req),
        .apb_rsp            (apb_rsp),
        .push               (push),
        .wr_data            (wr_data),
        .fifo_full          (fifo_full),
        .fifo_empty         (fifo_empty),
        .tx_busy            (tx_busy),
        .rx_byte            (rx_byte),
        .rx_valid_pulse     (rx_valid_pulse),
        .rx_frame_err_pulse (rx_frame_err_pulse)
    );

    uart_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .push      (push),
        .wr_data   (wr_data),
        .pop       (rd_req),
        .rd_data   (rd_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    uart_tx #(.OVERSAMPLE(OVERSAMPLE)) i_tx (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .rd_data   (rd_data),
        .empty     (fifo_empty),
        .rd_req    (rd_req),
        .txd       (txd),
        .busy      (tx_busy)
    );

    uart_rx #(.OVERSAMPLE(OVERSAMPLE)) i_rx (
        .uart_clk           (uart_clk),
        .sys_rst_n          (sys_rst_n),
        .rxd                (rxd),
        .rx_byte            (rx_byte),
        .rx_valid_pulse     (rx_valid_pulse),
        .rx_frame_err_pulse (rx_frame_err_pulse)
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int OVERSAMPLE = 16                              // clocks per bit
) (
    input  logic                                uart_clk,
    input  logic                                sys_rst_n,
    input  logic [uart_cfg_pkg::data_bits-1:0]  rd_data,       // FIFO head
    input  logic                                empty,         // FIFO empty flag
    output logic                                rd_req,        // one cycle pop strobe
    output logic                                txd,           // serial line, idles high
    output logic                                busy           // slot in progress
);
    import uart_cfg_pkg::*;

    localparam int slot_len = slot_bits * OVERSAMPLE;
    localparam int cnt_w    = $clog2(slot_len);
    // idle and fetch add two cycles, so shifting stops early to keep the slot length
    localparam logic [cnt_w-1:0] slot_last = cnt_w'(slot_len - 3);

    tx_state_e            state;
    logic [cnt_w-1:0]     cnt;                                 // position inside the slot
    logic [cnt_w-1:0]     bit_idx;                             // bit period of cnt, 0 is start
    logic                 bit_end;                             // last clock of a bit period
    logic [data_bits-1:0] shift_reg;                           // bits still to send, lsb next

    assign bit_idx = cnt / cnt_w'(OVERSAMPLE);
    assign bit_end = (cnt % cnt_w'(OVERSAMPLE)) == cnt_w'(OVERSAMPLE - 1);
    assign rd_req  = (state == tx_fetch);
    assign busy    = (state != tx_idle);

    // slot counter and state
    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= tx_idle;
            cnt   <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (!empty)
                        state <= tx_fetch;                     // byte waiting, slot is over
                end
                tx_fetch: begin
                    cnt   <= '0;                               // start bit begins next cycle
                    state <= tx_shift;
                end
                tx_shift: begin
                    if (cnt == slot_last)
                        state <= tx_idle;
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // line driver, decoded from the counter
    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            txd       <= 1'b1;
            shift_reg <= '0;
        end else if (state == tx_fetch) begin
            shift_reg <= rd_data;                              // capture with the pop
            txd       <= 1'b0;                                 // start bit
        end else if (state == tx_shift && bit_end) begin
            if (bit_idx < cnt_w'(data_bits)) begin
                txd       <= shift_reg[0];                     // next data bit, lsb first
                shift_reg <= shift_reg >> 1;
            end else begin
                txd <= 1'b1;                                   // stop level to end of slot
            end
        end
    end

    a_idle_high: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        state == tx_idle |-> txd);

    a_req_single: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        rd_req |=> !rd_req);

endmodule

`default_nettype wire

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 8                               // power of two
) (
    input  logic                                uart_clk,
    input  logic                                sys_rst_n,
    input  logic                                push,          // write strobe from the regs
    input  logic [uart_cfg_pkg::data_bits-1:0]  wr_data,
    input  logic                                pop,           // rd_req from the transmitter
    output logic [uart_cfg_pkg::data_bits-1:0]  rd_data,       // head of the queue, always shown
    output logic                                full,
    output logic                                empty
);
    import uart_cfg_pkg::*;

    localparam int addr_w = $clog2(FIFO_DEPTH);

    logic [data_bits-1:0] mem [FIFO_DEPTH];                    // byte storage
    logic [addr_w:0]      wr_ptr;                              // extra msb is the wrap flag
    logic [addr_w:0]      rd_ptr;

    // pointer update
    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge uart_clk) begin
        if (push)
            mem[wr_ptr[addr_w-1:0]] <= wr_data;                // storage only, no reset
    end

    assign rd_data = mem[rd_ptr[addr_w-1:0]];                  // fall-through head
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                     (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]); // same slot, wrapped once

    // the register block must refuse a write when full
    a_no_push_full: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        push |-> !full);

    // the transmitter only fetches when the FIFO holds data
    a_no_pop_empty: assert property (@(posedge uart_clk) disable iff (!sys_rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sources.f --top-module uart_tb -o uart_sim

out=$(./obj_dir/uart_sim)
echo "$out"

# exit status follows the search for the pass line
echo "$out" | grep -q "^Everything OK$"

// ==== sources.f ====
logic/uart_cfg_pkg.sv
logic/uart_bus_pkg.sv
logic/uart_tx_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_apb_regs.sv
logic/uart_top.sv
dv/uart_checker.sv
dv/uart_tb.sv
